/* Bender.yml */
package:
  name: render

sources:
  - render_pkg.sv
  - pix_inc.sv
  - dispatch.sv
  - escape_worker.sv
  - worker_bank.sv
  - result_merge.sv
  - render_top.sv
  - target: test
    files:
      - render_asserts.sv
      - tb_render.sv

/* compile.f */
render_pkg.sv
pix_inc.sv
dispatch.sv
escape_worker.sv
worker_bank.sv
result_merge.sv
render_top.sv
render_asserts.sv
tb_render.sv

/* dispatch.sv */
// Issues at most one pixel every 3 cycles; the lowest-numbered ready worker always wins
`timescale 1ns/1ps

module dispatch #(
	parameter int NUM_WORKERS = 16
) (
	input logic clk,
	input logic n_rst,
	input logic start,
	input logic [NUM_WORKERS-1:0] worker_ready,
	output logic [NUM_WORKERS-1:0] worker_start,
	output render_pkg::coord_t job_x,
	output render_pkg::coord_t job_y,
	output logic counter_enable,
	output logic counter_clear,
	input logic scan_done,
	input render_pkg::coord_t x_value,
	input render_pkg::coord_t y_value,
	output logic frame_done
);

	typedef enum logic [2:0] {IDLE, SEARCH, REST, ASSIGN, DONE} state_t;

	state_t state;
	state_t next_state;
	logic [NUM_WORKERS-1:0] pick;
	logic found;
	logic assign_now;

	// Lowest ready worker
	always_comb begin
		pick = '0;
		found = 1'b0;
		for (int i = 0; i < NUM_WORKERS; i++) begin
			if (worker_ready[i] && !found) begin
				pick[i] = 1'b1;
				found = 1'b1;
			end
		end
	end

	always_comb begin
		next_state = state;
		assign_now = 1'b0;
		case (state)
			IDLE: begin
				if (start)
					next_state = SEARCH;
			end
			SEARCH: begin
				if (scan_done) begin
					next_state = DONE;
				end else if (found) begin
					next_state = REST;
					assign_now = 1'b1;
				end
			end
			REST: next_state = ASSIGN;
			ASSIGN: next_state = SEARCH;
			DONE: begin
				// Wait for every worker to drain
				if (&worker_ready)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			state <= IDLE;
			worker_start <= '0;
			counter_enable <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			state <= next_state;
			worker_start <= assign_now ? pick : '0;
			counter_enable <= assign_now;
			frame_done <= (state == DONE) && (&worker_ready);
		end
	end

	// Job coordinate goes out with the start pulse
	always_ff @(posedge clk) begin
		if (assign_now) begin
			job_x <= x_value;
			job_y <= y_value;
		end
	end

	assign counter_clear = (state == IDLE);

endmodule

/* escape_worker.sv */
// Q3.12 with truncating shifts; z wraps silently for c far outside the +-8 range
`timescale 1ns/1ps

module escape_worker #(
	parameter render_pkg::iter_t MAX_ITER = 8'd64
) (
	input logic clk,
	input logic n_rst,
	input logic start,
	input render_pkg::coord_t job_x,
	input render_pkg::coord_t job_y,
	output logic ready,
	output logic res_valid,
	output render_pkg::coord_t res_x,
	output render_pkg::coord_t res_y,
	output render_pkg::iter_t res_iter,
	input logic res_ack
);

	import render_pkg::*;

	typedef enum logic [1:0] {IDLE, ITERATE, HOLD} state_t;

	state_t state;
	fix_t zr;
	fix_t zi;
	fix_t cr;
	fix_t ci;
	iter_t count;
	logic signed [31:0] x_wide;
	logic signed [31:0] y_wide;
	logic signed [31:0] c_re_wide;
	logic signed [31:0] c_im_wide;
	logic signed [31:0] rr;
	logic signed [31:0] ii;
	logic signed [31:0] ri;
	logic signed [31:0] mag;
	logic signed [31:0] re_sum;
	logic signed [31:0] im_sum;
	logic finish;

	assign x_wide = {22'd0, job_x};
	assign y_wide = {22'd0, job_y};
	assign c_re_wide = x_wide * STEP + RE_ORIGIN;
	assign c_im_wide = y_wide * STEP + IM_ORIGIN;

	assign rr = (zr * zr) >>> FRAC_BITS;
	assign ii = (zi * zi) >>> FRAC_BITS;
	assign ri = (zr * zi) >>> FRAC_BITS;
	assign mag = rr + ii;
	// z^2 + c, cut back to 16 bits
	assign re_sum = rr - ii + cr;
	assign im_sum = (ri <<< 1) + ci;

	assign finish = (mag > ESCAPE_LIMIT) || (count == MAX_ITER);

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (start) state <= ITERATE;
				ITERATE: if (finish) state <= HOLD;
				HOLD: if (res_ack) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			res_x <= job_x;
			res_y <= job_y;
			cr <= c_re_wide[15:0];
			ci <= c_im_wide[15:0];
			zr <= '0;
			zi <= '0;
			count <= '0;
		end else if (state == ITERATE && !finish) begin
			zr <= re_sum[15:0];
			zi <= im_sum[15:0];
			count <= count + 1'b1;
		end
	end

	assign ready = (state == IDLE);
	assign res_valid = (state == HOLD);
	assign res_iter = count;

endmodule

/* pix_inc.sv */
// Raster order, x fastest; done holds after the last pixel until clear is raised
`timescale 1ns/1ps

module pix_inc #(
	parameter render_pkg::coord_t X_MAX = 10'd639,
	parameter render_pkg::coord_t Y_MAX = 10'd479
) (
	input logic clk,
	input logic n_rst,
	input logic clear,
	input logic counter_enable,
	output render_pkg::coord_t x_value,
	output render_pkg::coord_t y_value,
	output logic done
);

	always_ff @(posedge clk) begin
		if (!n_rst || clear) begin
			x_value <= '0;
			y_value <= '0;
			done <= 1'b0;
		end else if (counter_enable && !done) begin
			if (x_value == X_MAX) begin
				x_value <= '0;
				if (y_value == Y_MAX) begin
					// Last pixel issued
					y_value <= '0;
					done <= 1'b1;
				end else begin
					y_value <= y_value + 1'b1;
				end
			end else begin
				x_value <= x_value + 1'b1;
			end
		end
	end

endmodule

/* render_asserts.sv */
// Generic checks; tie unused inputs to zero where a bound target lacks the signal
`timescale 1ns/1ps

module render_asserts #(
	parameter int W = 1
) (
	input logic clk,
	input logic n_rst,
	input logic [W-1:0] grant,
	input logic pulse,
	input logic spend,
	input render_pkg::credit_t held
);

	int fails = 0;

	// At most one worker started per cycle
	onehot_grant: assert property (@(posedge clk) disable iff (!n_rst) $onehot0(grant))
	else begin
		$error("worker start is not one-hot");
		fails++;
	end

	single_pulse: assert property (@(posedge clk) disable iff (!n_rst) pulse |=> !pulse)
	else begin
		$error("frame done pulse lasted more than one cycle");
		fails++;
	end

	// Credit of the result on the output is still held in that cycle
	spend_with_credit: assert property (@(posedge clk) disable iff (!n_rst) spend |-> held != '0)
	else begin
		$error("result sent with no credit held");
		fails++;
	end

endmodule

/* render_pkg.sv */
// Q3.12 fixed point, frames up to 1024x1024, at most 15 output credits held at once
package render_pkg;

	// Pixel coordinate
	typedef logic [9:0] coord_t;

	// Signed Q3.12 value
	typedef logic signed [15:0] fix_t;

	typedef logic [7:0] iter_t;

	typedef logic [3:0] credit_t;

	localparam int FRAC_BITS = 12;

	// 4.0 in Q3.12
	localparam fix_t ESCAPE_LIMIT = 16'sd16384;

	// c at pixel (0,0) is -2.0 - 1.0i
	localparam fix_t RE_ORIGIN = -16'sd8192;
	localparam fix_t IM_ORIGIN = -16'sd4096;

	// 0.25 per pixel
	localparam fix_t STEP = 16'sd1024;

endpackage

/* render_top.sv */
// NUM_WORKERS must be even; output order follows completion, not raster order
`timescale 1ns/1ps

module render_top #(
	parameter render_pkg::coord_t X_MAX = 10'd639,
	parameter render_pkg::coord_t Y_MAX = 10'd479,
	parameter int NUM_WORKERS = 16,
	parameter render_pkg::iter_t MAX_ITER = 8'd64
) (
	input logic clk,
	input logic n_rst,
	input logic start,
	input logic out_credit,
	output logic out_valid,
	output render_pkg::coord_t out_x,
	output render_pkg::coord_t out_y,
	output render_pkg::iter_t out_iter,
	output logic frame_done
);

	import render_pkg::*;

	localparam int HALF = NUM_WORKERS / 2;

	coord_t x_value;
	coord_t y_value;
	coord_t job_x;
	coord_t job_y;
	coord_t a_x;
	coord_t a_y;
	coord_t b_x;
	coord_t b_y;
	iter_t a_iter;
	iter_t b_iter;
	logic counter_enable;
	logic counter_clear;
	logic scan_done;
	logic a_valid;
	logic a_ack;
	logic b_valid;
	logic b_ack;
	logic [NUM_WORKERS-1:0] worker_ready;
	logic [NUM_WORKERS-1:0] worker_start;

	pix_inc #(
		.X_MAX(X_MAX),
		.Y_MAX(Y_MAX)
	) pix_inc_i (
		.clk(clk),
		.n_rst(n_rst),
		.clear(counter_clear),
		.counter_enable(counter_enable),
		.x_value(x_value),
		.y_value(y_value),
		.done(scan_done)
	);

	dispatch #(
		.NUM_WORKERS(NUM_WORKERS)
	) dispatch_i (
		.clk(clk),
		.n_rst(n_rst),
		.start(start),
		.worker_ready(worker_ready),
		.worker_start(worker_start),
		.job_x(job_x),
		.job_y(job_y),
		.counter_enable(counter_enable),
		.counter_clear(counter_clear),
		.scan_done(scan_done),
		.x_value(x_value),
		.y_value(y_value),
		.frame_done(frame_done)
	);

	// Bank A takes the low half of the worker vector
	worker_bank #(
		.BANK_WORKERS(HALF),
		.MAX_ITER(MAX_ITER)
	) bank_a_i (
		.clk(clk),
		.n_rst(n_rst),
		.start(worker_start[HALF-1:0]),
		.job_x(job_x),
		.job_y(job_y),
		.ready(worker_ready[HALF-1:0]),
		.bank_valid(a_valid),
		.bank_x(a_x),
		.bank_y(a_y),
		.bank_iter(a_iter),
		.bank_ack(a_ack)
	);

	worker_bank #(
		.BANK_WORKERS(HALF),
		.MAX_ITER(MAX_ITER)
	) bank_b_i (
		.clk(clk),
		.n_rst(n_rst),
		.start(worker_start[NUM_WORKERS-1:HALF]),
		.job_x(job_x),
		.job_y(job_y),
		.ready(worker_ready[NUM_WORKERS-1:HALF]),
		.bank_valid(b_valid),
		.bank_x(b_x),
		.bank_y(b_y),
		.bank_iter(b_iter),
		.bank_ack(b_ack)
	);

	result_merge result_merge_i (
		.clk(clk),
		.n_rst(n_rst),
		.a_valid(a_valid),
		.a_x(a_x),
		.a_y(a_y),
		.a_iter(a_iter),
		.a_ack(a_ack),
		.b_valid(b_valid),
		.b_x(b_x),
		.b_y(b_y),
		.b_iter(b_iter),
		.b_ack(b_ack),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_x(out_x),
		.out_y(out_y),
		.out_iter(out_iter)
	);

endmodule

/* result_merge.sv */
// Sink may hold at most 15 credits outstanding; the counter wraps past that
`timescale 1ns/1ps

module result_merge (
	input logic clk,
	input logic n_rst,
	input logic a_valid,
	input render_pkg::coord_t a_x,
	input render_pkg::coord_t a_y,
	input render_pkg::iter_t a_iter,
	output logic a_ack,
	input logic b_valid,
	input render_pkg::coord_t b_x,
	input render_pkg::coord_t b_y,
	input render_pkg::iter_t b_iter,
	output logic b_ack,
	input logic out_credit,
	output logic out_valid,
	output render_pkg::coord_t out_x,
	output render_pkg::coord_t out_y,
	output render_pkg::iter_t out_iter
);

	import render_pkg::*;

	credit_t credit;
	logic free;
	logic take_a;
	logic take_b;
	logic prefer_b;

	// Credit of the result now on the output is still counted
	assign free = (credit > credit_t'(out_valid));

	always_comb begin
		take_a = 1'b0;
		take_b = 1'b0;
		if (free) begin
			if (a_valid && b_valid) begin
				take_a = !prefer_b;
				take_b = prefer_b;
			end else begin
				take_a = a_valid;
				take_b = b_valid;
			end
		end
	end

	assign a_ack = take_a;
	assign b_ack = take_b;

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			credit <= '0;
			out_valid <= 1'b0;
			prefer_b <= 1'b0;
		end else begin
			out_valid <= take_a || take_b;
			credit <= credit + credit_t'(out_credit) - credit_t'(out_valid);
			// Swap priority only on a contested grant
			if (free && a_valid && b_valid)
				prefer_b <= !prefer_b;
		end
	end

	always_ff @(posedge clk) begin
		if (take_a) begin
			out_x <= a_x;
			out_y <= a_y;
			out_iter <= a_iter;
		end else if (take_b) begin
			out_x <= b_x;
			out_y <= b_y;
			out_iter <= b_iter;
		end
	end

endmodule

/* tb_render.sv */
// 6x4 frame, 4 workers, MAX_ITER 20; credits stay at most 12 ahead so the 4-bit counter never wraps
`timescale 1ns/1ps

module tb_render;

	import render_pkg::*;

	localparam coord_t X_MAX = 10'd5;
	localparam coord_t Y_MAX = 10'd3;
	localparam int NUM_WORKERS = 4;
	localparam iter_t MAX_ITER = 8'd20;
	localparam int COLS = int'(X_MAX) + 1;
	localparam int NUM_PIXELS = COLS * (int'(Y_MAX) + 1);
	localparam int CREDIT_AHEAD = (1 << $bits(credit_t)) - 4;
	localparam int STALL_CYCLES = 60;
	localparam int GAP_MAX = 7;
	localparam int DRAIN_CYCLES = 5;
	localparam int TIMEOUT_CYCLES = 5 * NUM_PIXELS * (int'(MAX_ITER) + 8);

	logic clk;
	logic n_rst;
	logic start;
	logic out_credit;
	logic out_valid;
	coord_t out_x;
	coord_t out_y;
	iter_t out_iter;
	logic frame_done;

	coord_t res_x[$];
	coord_t res_y[$];
	iter_t res_iter[$];
	integer seed;
	int given;
	int frames_done;
	int cycles;
	int errors;
	int pass_count;
	int fail_count;
	int assert_fails;

	render_top #(
		.X_MAX(X_MAX),
		.Y_MAX(Y_MAX),
		.NUM_WORKERS(NUM_WORKERS),
		.MAX_ITER(MAX_ITER)
	) dut_i (
		.clk(clk),
		.n_rst(n_rst),
		.start(start),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_x(out_x),
		.out_y(out_y),
		.out_iter(out_iter),
		.frame_done(frame_done)
	);

	bind dispatch render_asserts #(.W(NUM_WORKERS)) dispatch_asserts_i (
		.clk(clk),
		.n_rst(n_rst),
		.grant(worker_start),
		.pulse(frame_done),
		.spend(1'b0),
		.held('0)
	);

	bind result_merge render_asserts #(.W(1)) merge_asserts_i (
		.clk(clk),
		.n_rst(n_rst),
		.grant(1'b0),
		.pulse(1'b0),
		.spend(out_valid),
		.held(credit)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	// Outputs change on the rising edge, so sample on the falling one
	always @(negedge clk) begin
		if (n_rst && out_valid) begin
			res_x.push_back(out_x);
			res_y.push_back(out_y);
			res_iter.push_back(out_iter);
		end
		if (n_rst && frame_done)
			frames_done++;
	end

	// Escape count straight from the Q3.12 rule, truncating shifts
	function automatic iter_t model_count(input coord_t x, input coord_t y);
		fix_t cr;
		fix_t ci;
		fix_t zr;
		fix_t zi;
		int re2;
		int im2;
		int prod_ri;
		int n;
		logic escaped;
		cr = fix_t'(int'(RE_ORIGIN) + int'(x) * int'(STEP));
		ci = fix_t'(int'(IM_ORIGIN) + int'(y) * int'(STEP));
		zr = '0;
		zi = '0;
		n = 0;
		escaped = 1'b0;
		while (!escaped && n < int'(MAX_ITER)) begin
			re2 = (int'(zr) * int'(zr)) >>> FRAC_BITS;
			im2 = (int'(zi) * int'(zi)) >>> FRAC_BITS;
			if (re2 + im2 > int'(ESCAPE_LIMIT)) begin
				escaped = 1'b1;
			end else begin
				prod_ri = (int'(zr) * int'(zi)) >>> FRAC_BITS;
				zr = fix_t'(re2 - im2 + int'(cr));
				zi = fix_t'(2 * prod_ri + int'(ci));
				n++;
			end
		end
		return iter_t'(n);
	endfunction

	task automatic check_iter(input string name, input iter_t expected, input iter_t actual);
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s: expected %0d, got %0d", name, expected, actual);
		end
	endtask

	task automatic check_coord(input string name, input coord_t expected, input coord_t actual);
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s: expected %0d, got %0d", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			errors++;
			$display("FAIL %s: expected %0d, got %0d", name, expected, actual);
		end
	endtask

	task automatic check_credit_gap(input string name, input int credits, input int received);
		if (received > credits) begin
			errors++;
			$display("FAIL %s credit gap: expected at most %0d results, got %0d",
				name, credits, received);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			pass_count++;
			$display("%s: passed", name);
		end else begin
			fail_count++;
			$display("%s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Sort the results into raster order, then compare coordinates and counts
	task automatic check_frame(input string name);
		coord_t sx [NUM_PIXELS];
		coord_t sy [NUM_PIXELS];
		iter_t si [NUM_PIXELS];
		coord_t ex;
		coord_t ey;
		int fill;
		fill = 0;
		check_count({name, " result count"}, NUM_PIXELS, res_x.size());
		for (int p = 0; p < NUM_PIXELS; p++) begin
			ex = coord_t'(p % COLS);
			ey = coord_t'(p / COLS);
			for (int k = 0; k < res_x.size(); k++) begin
				if (res_x[k] == ex && res_y[k] == ey && fill < NUM_PIXELS) begin
					sx[fill] = res_x[k];
					sy[fill] = res_y[k];
					si[fill] = res_iter[k];
					fill++;
				end
			end
		end
		for (int i = 0; i < fill; i++) begin
			check_coord($sformatf("%s x of result %0d", name, i), coord_t'(i % COLS), sx[i]);
			check_coord($sformatf("%s y of result %0d", name, i), coord_t'(i / COLS), sy[i]);
			check_iter($sformatf("%s iter at (%0d,%0d)", name, sx[i], sy[i]),
				model_count(sx[i], sy[i]), si[i]);
		end
		if (fill < NUM_PIXELS) begin
			errors++;
			$display("%s: %0d pixels of the frame never came out", name, NUM_PIXELS - fill);
		end
	endtask

	task automatic reset_quiet_test();
		int errors_before;
		errors_before = errors;
		repeat (10) begin
			@(negedge clk);
			if (out_valid !== 1'b0) begin
				errors++;
				$display("reset_quiet: out_valid rose with no credit and no start");
			end
			if (frame_done !== 1'b0) begin
				errors++;
				$display("reset_quiet: frame_done rose with no start");
			end
		end
		report_test("reset_quiet", errors_before);
	endtask

	// hold_cycles withholds all credit first; gap_max above zero spaces credits randomly
	task automatic run_frame(input string name, input int hold_cycles, input int gap_max);
		int errors_before;
		int f0;
		int hold_left;
		int gap;
		errors_before = errors;
		f0 = frames_done;
		hold_left = hold_cycles;
		gap = 0;
		given = 0;
		res_x.delete();
		res_y.delete();
		res_iter.delete();
		pulse_start();
		while (res_x.size() < NUM_PIXELS || frames_done == f0) begin
			@(posedge clk);
			if (hold_left > 0) begin
				hold_left--;
				out_credit <= 1'b0;
			end else if (gap > 0) begin
				gap--;
				out_credit <= 1'b0;
			end else if (given < NUM_PIXELS && given - res_x.size() < CREDIT_AHEAD) begin
				out_credit <= 1'b1;
				given++;
				if (gap_max > 0)
					gap = 1 + {$random(seed)} % gap_max;
			end else begin
				out_credit <= 1'b0;
			end
			check_credit_gap(name, given, res_x.size());
		end
		@(posedge clk);
		out_credit <= 1'b0;
		repeat (DRAIN_CYCLES) @(posedge clk);
		check_count({name, " frame_done pulses"}, 1, frames_done - f0);
		check_frame(name);
		report_test(name, errors_before);
	endtask

	initial begin
		seed = 96405;
		clk = 1'b0;
		n_rst = 1'b0;
		start = 1'b0;
		out_credit = 1'b0;
		given = 0;
		frames_done = 0;
		cycles = 0;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		repeat (8) @(posedge clk);
		n_rst <= 1'b1;

		reset_quiet_test();
		run_frame("full_frame", 0, 0);
		run_frame("credit_stall", STALL_CYCLES, 0);
		run_frame("random_credit", 0, GAP_MAX);
		run_frame("second_frame", 0, 0);

		assert_fails = dut_i.dispatch_i.dispatch_asserts_i.fails
			+ dut_i.result_merge_i.merge_asserts_i.fails;
		$display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
			pass_count, fail_count, assert_fails);
		if (errors == 0 && fail_count == 0 && assert_fails == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* worker_bank.sv */
// Results leave in completion order; one result per cycle at most, held until bank_ack
`timescale 1ns/1ps

module worker_bank #(
	parameter int BANK_WORKERS = 8,
	parameter render_pkg::iter_t MAX_ITER = 8'd64
) (
	input logic clk,
	input logic n_rst,
	input logic [BANK_WORKERS-1:0] start,
	input render_pkg::coord_t job_x,
	input render_pkg::coord_t job_y,
	output logic [BANK_WORKERS-1:0] ready,
	output logic bank_valid,
	output render_pkg::coord_t bank_x,
	output render_pkg::coord_t bank_y,
	output render_pkg::iter_t bank_iter,
	input logic bank_ack
);

	import render_pkg::*;

	localparam int IDX_W = (BANK_WORKERS > 1) ? $clog2(BANK_WORKERS) : 1;

	logic [BANK_WORKERS-1:0] w_valid;
	logic [BANK_WORKERS-1:0] w_ack;
	coord_t w_x [BANK_WORKERS];
	coord_t w_y [BANK_WORKERS];
	iter_t w_iter [BANK_WORKERS];
	logic [IDX_W-1:0] ptr;
	logic [IDX_W-1:0] grant;
	logic any_valid;
	logic load;

	for (genvar g = 0; g < BANK_WORKERS; g++) begin : gen_worker
		escape_worker #(
			.MAX_ITER(MAX_ITER)
		) worker_i (
			.clk(clk),
			.n_rst(n_rst),
			.start(start[g]),
			.job_x(job_x),
			.job_y(job_y),
			.ready(ready[g]),
			.res_valid(w_valid[g]),
			.res_x(w_x[g]),
			.res_y(w_y[g]),
			.res_iter(w_iter[g]),
			.res_ack(w_ack[g])
		);
	end

	// First finished worker at or after ptr
	always_comb begin : rr_pick
		int idx;
		grant = '0;
		any_valid = 1'b0;
		for (int k = 0; k < BANK_WORKERS; k++) begin
			idx = int'(ptr) + k;
			if (idx >= BANK_WORKERS)
				idx = idx - BANK_WORKERS;
			if (w_valid[idx] && !any_valid) begin
				grant = IDX_W'(idx);
				any_valid = 1'b1;
			end
		end
	end

	assign load = any_valid && (!bank_valid || bank_ack);

	always_comb begin
		w_ack = '0;
		if (load)
			w_ack[grant] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			bank_valid <= 1'b0;
			ptr <= '0;
		end else if (load) begin
			bank_valid <= 1'b1;
			ptr <= (grant == IDX_W'(BANK_WORKERS - 1)) ? '0 : grant + 1'b1;
		end else if (bank_ack) begin
			bank_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			bank_x <= w_x[grant];
			bank_y <= w_y[grant];
			bank_iter <= w_iter[grant];
		end
	end

endmodule
